// ==== logic/core_pkg.sv ====
`default_nettype none

package core_pkg;

    localparam int RW        = 16;
    localparam int I_SIZE    = 32;
    localparam int REGNO     = 8;
    localparam int REGNO_LOG = 3;

    // instruction word field positions
    localparam int F_OP_LSB  = 12;
    localparam int F_RD_LSB  = 9;
    localparam int F_RA_LSB  = 6;
    localparam int F_RB_LSB  = 3;
    localparam int F_IMM_LSB = 16;

    typedef enum logic [3:0] {
        NOP  = 4'd0,
        ADD  = 4'd1,
        SUB  = 4'd2,
        AND  = 4'd3,
        OR   = 4'd4,
        XOR  = 4'd5,
        ADDI = 4'd6,
        LD   = 4'd7,
        ST   = 4'd8,
        BEQZ = 4'd9,
        JMP  = 4'd10,
        HALT = 4'd11
    } opcode_e;

    typedef struct packed {
        logic [I_SIZE-1:0] instr;
        logic [RW-1:0]     pc;
    } fd_t;

    typedef struct packed {
        opcode_e              alu_op;
        logic [REGNO_LOG-1:0] rd;
        logic [REGNO_LOG-1:0] ra;
        logic [REGNO_LOG-1:0] rb;
        logic                 use_imm;
        logic                 reg_we;
        logic                 load;
        logic                 store;
        logic                 beqz;
        logic                 jump;
        logic                 halt;
        logic [RW-1:0]        imm;
    } de_t;

    typedef struct packed {
        logic [RW-1:0]        data;   // alu result or store data
        logic [RW-1:0]        addr;
        logic [REGNO_LOG-1:0] rd;
        logic                 reg_we;
        logic                 load;
        logic                 store;
    } ew_t;

    typedef struct packed {
        logic                 valid;
        logic [REGNO_LOG-1:0] rd;
        logic [RW-1:0]        data;
    } wb_t;

endpackage

`default_nettype wire

// ==== logic/fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch #(
    parameter logic [core_pkg::RW-1:0] START_PC = '0
) (
    input  wire                         i_clk,
    input  wire                         i_arst_n,
    output logic [core_pkg::RW-1:0]     o_req_addr,
    output logic                        o_req_valid,
    input  wire  [core_pkg::I_SIZE-1:0] i_req_data,
    input  wire                         i_req_data_valid,
    input  wire                         i_next_ready,
    output logic                        o_submit,
    output core_pkg::fd_t               o_fd,
    input  wire                         i_flush,
    input  wire  [core_pkg::RW-1:0]     i_flush_pc,
    input  wire                         i_stop
);
    import core_pkg::*;

    logic [RW-1:0] pc_q;
    logic          req_q;
    logic          discard_q;
    logic          resp;
    logic          issue;

    assign resp = req_q && i_req_data_valid;
    // only request when the response has a free slot to land in
    assign issue = !req_q && !i_flush && !i_stop && (!o_submit || i_next_ready);

    assign o_req_valid = req_q && !i_req_data_valid;   // drops with the response

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q      <= START_PC;
            req_q     <= 1'b0;
            discard_q <= 1'b0;
            o_submit  <= 1'b0;
        end else begin
            if (issue) begin
                req_q <= 1'b1;
            end else if (resp) begin
                req_q <= 1'b0;
            end

            if (i_flush) begin
                pc_q      <= i_flush_pc;
                o_submit  <= 1'b0;
                discard_q <= req_q && !i_req_data_valid;   // stale if still in flight
            end else if (resp && !discard_q) begin
                pc_q     <= o_req_addr + 1'b1;
                o_submit <= 1'b1;
            end else begin
                if (resp) begin
                    discard_q <= 1'b0;
                end
                if (i_next_ready) begin
                    o_submit <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (issue) begin
            o_req_addr <= pc_q;
        end
        if (resp && !discard_q && !i_flush) begin
            o_fd.instr <= i_req_data;
            o_fd.pc    <= o_req_addr;
        end
    end

endmodule

`default_nettype wire

// ==== logic/decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode (
    input  wire                 i_clk,
    input  wire                 i_arst_n,
    input  wire                 i_submit,
    input  wire core_pkg::fd_t  i_fd,
    output logic                o_ready,
    output logic                o_submit,
    output core_pkg::de_t       o_de,
    input  wire                 i_next_ready,
    input  wire                 i_flush
);
    import core_pkg::*;

    opcode_e op;
    de_t     de_d;

    assign op      = opcode_e'(i_fd.instr[F_OP_LSB +: $bits(opcode_e)]);
    assign o_ready = !o_submit || i_next_ready;

    always_comb begin
        de_d        = '0;
        de_d.alu_op = ADD;   // address and addi also go through the adder
        de_d.rd     = i_fd.instr[F_RD_LSB +: REGNO_LOG];
        de_d.ra     = i_fd.instr[F_RA_LSB +: REGNO_LOG];
        de_d.rb     = i_fd.instr[F_RB_LSB +: REGNO_LOG];
        de_d.imm    = i_fd.instr[F_IMM_LSB +: RW];
        case (op)
            ADD, SUB, AND, OR, XOR: begin
                de_d.alu_op = op;
                de_d.reg_we = 1'b1;
            end
            ADDI: begin
                de_d.use_imm = 1'b1;
                de_d.reg_we  = 1'b1;
            end
            LD: begin
                de_d.use_imm = 1'b1;
                de_d.reg_we  = 1'b1;
                de_d.load    = 1'b1;
            end
            ST: begin
                de_d.use_imm = 1'b1;   // rb carries the store data
                de_d.store   = 1'b1;
            end
            BEQZ: begin
                de_d.beqz = 1'b1;
            end
            JMP: begin
                de_d.jump = 1'b1;
            end
            HALT: begin
                de_d.halt = 1'b1;
            end
            default: begin
                de_d.alu_op = NOP;   // nop and unused codes
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_submit <= 1'b0;
        end else if (i_flush) begin
            o_submit <= 1'b0;
        end else if (o_ready) begin
            o_submit <= i_submit;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_submit && o_ready) begin
            o_de <= de_d;
        end
    end

endmodule

`default_nettype wire

// ==== logic/execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute #(
    parameter logic [core_pkg::RW-1:0] START_PC = '0
) (
    input  wire                     i_clk,
    input  wire                     i_arst_n,
    input  wire                     i_submit,
    input  wire core_pkg::de_t      i_de,
    output logic                    o_ready,
    output logic                    o_submit,
    output core_pkg::ew_t           o_ew,
    input  wire                     i_next_ready,
    input  wire core_pkg::wb_t      i_wb,
    output logic                    o_flush,
    output logic [core_pkg::RW-1:0] o_flush_pc,
    output logic                    o_stop,
    output logic                    o_halted,
    output logic [core_pkg::RW-1:0] o_dbg_r0,
    output logic [core_pkg::RW-1:0] o_dbg_pc
);
    import core_pkg::*;

    logic [RW-1:0]    regs [REGNO];
    logic [REGNO-1:0] busy_q;
    logic [REGNO-1:0] busy_set;
    logic [REGNO-1:0] busy_clr;
    logic [RW-1:0]    pc_q;
    logic             stop_q;
    logic [RW-1:0]    src_a;
    logic [RW-1:0]    src_b;
    logic [RW-1:0]    rhs;
    logic [RW-1:0]    alu_res;
    logic             hazard;
    logic             take;
    logic             taken;
    logic             to_mem;

    assign src_a = regs[i_de.ra];
    assign src_b = regs[i_de.rb];
    assign rhs   = i_de.use_imm ? i_de.imm : src_b;

    // dest check too, so only one write per register is ever in flight
    assign hazard = busy_q[i_de.ra] || busy_q[i_de.rb] || (i_de.reg_we && busy_q[i_de.rd]);
    assign o_ready = !stop_q && !hazard && (!o_submit || i_next_ready);
    assign take    = i_submit && o_ready;
    assign to_mem  = i_de.reg_we || i_de.store;

    always_comb begin
        case (i_de.alu_op)
            SUB:     alu_res = src_a - rhs;
            AND:     alu_res = src_a & rhs;
            OR:      alu_res = src_a | rhs;
            XOR:     alu_res = src_a ^ rhs;
            default: alu_res = src_a + rhs;
        endcase
    end

    assign taken      = i_de.jump || (i_de.beqz && src_a == '0);
    assign o_flush    = take && taken;
    assign o_flush_pc = i_de.imm;
    assign o_stop     = stop_q || (take && i_de.halt);
    assign o_dbg_r0   = regs[0];
    assign o_dbg_pc   = pc_q;

    always_comb begin
        busy_set = '0;
        busy_clr = '0;
        if (take && i_de.reg_we) begin
            busy_set[i_de.rd] = 1'b1;
        end
        if (i_wb.valid) begin
            busy_clr[i_wb.rd] = 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < REGNO; i++) begin
                regs[i] <= '0;
            end
            busy_q   <= '0;
            pc_q     <= START_PC;
            stop_q   <= 1'b0;
            o_halted <= 1'b0;
            o_submit <= 1'b0;
        end else begin
            if (i_wb.valid) begin
                regs[i_wb.rd] <= i_wb.data;
            end
            busy_q <= (busy_q & ~busy_clr) | busy_set;
            if (take) begin
                pc_q     <= taken ? i_de.imm : pc_q + 1'b1;
                o_submit <= to_mem;   // branches, nop and halt end here
            end else if (i_next_ready) begin
                o_submit <= 1'b0;
            end
            if (take && i_de.halt) begin
                stop_q <= 1'b1;
            end
            // memwb idle and nothing pending writeback
            if (stop_q && busy_q == '0 && !o_submit && i_next_ready) begin
                o_halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (take) begin
            o_ew.data   <= i_de.store ? src_b : alu_res;
            o_ew.addr   <= alu_res;
            o_ew.rd     <= i_de.rd;
            o_ew.reg_we <= i_de.reg_we;
            o_ew.load   <= i_de.load;
            o_ew.store  <= i_de.store;
        end
    end

endmodule

`default_nettype wire

// ==== logic/memwb.sv ====
`timescale 1ns/1ps
`default_nettype none

module memwb (
    input  wire                     i_clk,
    input  wire                     i_arst_n,
    input  wire                     i_submit,
    input  wire core_pkg::ew_t      i_ew,
    output logic                    o_ready,
    output core_pkg::wb_t           o_wb,
    output logic                    o_mem_req,
    output logic                    o_mem_we,
    output logic [core_pkg::RW-1:0] o_mem_addr,
    output logic [core_pkg::RW-1:0] o_mem_data,
    input  wire  [core_pkg::RW-1:0] i_mem_data,
    input  wire                     i_mem_ack
);
    import core_pkg::*;

    ew_t                  item_q;
    logic                 accept;
    logic                 ack;
    logic                 wb_valid_q;
    logic [REGNO_LOG-1:0] wb_rd_q;
    logic [RW-1:0]        wb_data_q;

    assign o_ready = !o_mem_req;   // alu items pass straight through
    assign accept  = i_submit && o_ready;
    assign ack     = o_mem_req && i_mem_ack;

    assign o_mem_we   = o_mem_req && item_q.store;
    assign o_mem_addr = item_q.addr;
    assign o_mem_data = item_q.data;
    assign o_wb       = '{valid: wb_valid_q, rd: wb_rd_q, data: wb_data_q};

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_mem_req  <= 1'b0;
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= 1'b0;   // single cycle pulse
            if (accept) begin
                o_mem_req  <= i_ew.load || i_ew.store;
                wb_valid_q <= i_ew.reg_we && !i_ew.load;
            end else if (ack) begin
                o_mem_req  <= 1'b0;
                wb_valid_q <= item_q.load;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            item_q    <= i_ew;
            wb_rd_q   <= i_ew.rd;
            wb_data_q <= i_ew.data;
        end else if (ack) begin
            wb_rd_q   <= item_q.rd;
            wb_data_q <= i_mem_data;   // load data valid with ack
        end
    end

endmodule

`default_nettype wire

// ==== logic/core.sv ====
`timescale 1ns/1ps
`default_nettype none

module core #(
    parameter logic [core_pkg::RW-1:0] START_PC = '0
) (
    input  wire                         i_clk,
    input  wire                         i_arst_n,
    output logic [core_pkg::RW-1:0]     o_req_addr,
    output logic                        o_req_valid,
    input  wire  [core_pkg::I_SIZE-1:0] i_req_data,
    input  wire                         i_req_data_valid,
    output logic                        o_mem_req,
    output logic                        o_mem_we,
    output logic [core_pkg::RW-1:0]     o_mem_addr,
    output logic [core_pkg::RW-1:0]     o_mem_data,
    input  wire  [core_pkg::RW-1:0]     i_mem_data,
    input  wire                         i_mem_ack,
    output logic                        o_halted,
    output logic [core_pkg::RW-1:0]     o_dbg_r0,
    output logic [core_pkg::RW-1:0]     o_dbg_pc
);
    import core_pkg::*;

    fd_t           fd;
    de_t           de;
    ew_t           ew;
    wb_t           wb;
    logic          fd_submit;
    logic          fd_ready;
    logic          de_submit;
    logic          de_ready;
    logic          ew_submit;
    logic          ew_ready;
    logic          flush;
    logic          stop;
    logic [RW-1:0] flush_pc;

    fetch #(.START_PC(START_PC)) fetch0 (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .o_req_addr(o_req_addr), .o_req_valid(o_req_valid),
        .i_req_data(i_req_data), .i_req_data_valid(i_req_data_valid),
        .i_next_ready(fd_ready), .o_submit(fd_submit), .o_fd(fd),
        .i_flush(flush), .i_flush_pc(flush_pc), .i_stop(stop)
    );

    decode decode0 (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_submit(fd_submit), .i_fd(fd), .o_ready(fd_ready),
        .o_submit(de_submit), .o_de(de), .i_next_ready(de_ready),
        .i_flush(flush)
    );

    execute #(.START_PC(START_PC)) execute0 (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_submit(de_submit), .i_de(de), .o_ready(de_ready),
        .o_submit(ew_submit), .o_ew(ew), .i_next_ready(ew_ready), .i_wb(wb),
        .o_flush(flush), .o_flush_pc(flush_pc), .o_stop(stop), .o_halted(o_halted),
        .o_dbg_r0(o_dbg_r0), .o_dbg_pc(o_dbg_pc)
    );

    memwb memwb0 (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_submit(ew_submit), .i_ew(ew), .o_ready(ew_ready), .o_wb(wb),
        .o_mem_req(o_mem_req), .o_mem_we(o_mem_we),
        .o_mem_addr(o_mem_addr), .o_mem_data(o_mem_data),
        .i_mem_data(i_mem_data), .i_mem_ack(i_mem_ack)
    );

endmodule

`default_nettype wire

// ==== tests/tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 8
) (
    output logic o_clk,
    output logic o_arst_n,
    input  wire  i_rst_req
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // reset at start, and again on every request pulse
    initial begin
        o_arst_n = 1'b0;
        forever begin
            repeat (RST_CYCLES) @(posedge o_clk);
            @(negedge o_clk);
            o_arst_n = 1'b1;
            @(posedge i_rst_req);
            @(negedge o_clk);
            o_arst_n = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== tests/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_tb;
    import core_pkg::*;

    localparam int N_TESTS      = 5;
    localparam int RUNS         = 2 * N_TESTS;   // random acks first, then 1-cycle acks
    localparam int PROG_WORDS   = 12;
    localparam int INIT_WORDS   = 4;
    localparam int MEM_WORDS    = 256;
    localparam int LIMIT_CYCLES = RUNS * PROG_WORDS * 40;
    localparam int SEED         = 32'h71fe_a711;

    logic clk;
    logic arst_n;
    logic rst_req = 1'b0;

    logic [RW-1:0]     req_addr;
    logic              req_valid;
    logic [I_SIZE-1:0] req_data       = '0;
    logic              req_data_valid = 1'b0;
    logic              mem_req;
    logic              mem_we;
    logic [RW-1:0]     mem_addr;
    logic [RW-1:0]     mem_wdata;
    logic [RW-1:0]     mem_rdata      = '0;
    logic              mem_ack        = 1'b0;
    logic              halted;
    logic [RW-1:0]     dbg_r0;
    logic [RW-1:0]     dbg_pc;

    logic [I_SIZE-1:0] imem [MEM_WORDS];
    logic [RW-1:0]     dmem [MEM_WORDS];
    int                ireq_wait   = 0;
    int                dreq_wait   = 0;
    int                cur_test    = 0;
    bit                fixed_delay = 1'b0;

    string             test_name [N_TESTS];
    logic [I_SIZE-1:0] prog_tab  [N_TESTS][PROG_WORDS];
    logic [RW-1:0]     data_tab  [N_TESTS][INIT_WORDS];
    logic [RW-1:0]     exp_r0    [N_TESTS];
    logic [RW-1:0]     exp_addr  [N_TESTS];
    logic [RW-1:0]     exp_word  [N_TESTS];
    int                fill_t;
    int                fill_n;
    int                errors = 0;
    int                passed = 0;
    int                failed = 0;

    tb_clkgen #(.PERIOD_NS(10), .RST_CYCLES(8)) clkgen0 (
        .o_clk(clk), .o_arst_n(arst_n), .i_rst_req(rst_req)
    );

    core #(.START_PC(16'h0000)) dut0 (
        .i_clk(clk), .i_arst_n(arst_n),
        .o_req_addr(req_addr), .o_req_valid(req_valid),
        .i_req_data(req_data), .i_req_data_valid(req_data_valid),
        .o_mem_req(mem_req), .o_mem_we(mem_we),
        .o_mem_addr(mem_addr), .o_mem_data(mem_wdata),
        .i_mem_data(mem_rdata), .i_mem_ack(mem_ack),
        .o_halted(halted), .o_dbg_r0(dbg_r0), .o_dbg_pc(dbg_pc)
    );

    function automatic logic [I_SIZE-1:0] halt_fill(input int a);
        return {8'h00, a[7:0], HALT, 12'h000};   // halt with the address in the spare imm bits
    endfunction

    function automatic logic [RW-1:0] data_fill(input int a);
        return {~a[7:0], a[7:0]};
    endfunction

    function automatic int pick_ack_delay();
        if (fixed_delay) begin
            return 1;
        end
        return int'($urandom_range(4, 1));
    endfunction

    task automatic check_value(input string what, input logic [RW-1:0] got,
                               input logic [RW-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic begin_test(input int t, input string name, input logic [RW-1:0] r0,
                              input logic [RW-1:0] addr, input logic [RW-1:0] word);
        fill_t = t;
        fill_n = 0;
        test_name[t] = name;
        exp_r0[t] = r0;
        exp_addr[t] = addr;
        exp_word[t] = word;
        for (int n = 0; n < PROG_WORDS; n++) begin
            prog_tab[t][n] = halt_fill(n);
        end
        for (int n = 0; n < INIT_WORDS; n++) begin
            data_tab[t][n] = data_fill(n);
        end
    endtask

    task automatic add_instr(input opcode_e op, input int rd, input int ra, input int rb,
                             input int imm);
        prog_tab[fill_t][fill_n] = {imm[15:0], op, rd[2:0], ra[2:0], rb[2:0], 3'b000};
        fill_n++;
    endtask

    task automatic build_table();
        begin_test(0, "alu_chain", 16'h360c, 16'h0010, 16'h360c);
        add_instr(XOR,  7, 7, 7, 0);          // r7 = 0 as base for the rest
        add_instr(ADDI, 1, 7, 0, 'h1234);
        add_instr(ADDI, 2, 1, 0, 'h0111);
        add_instr(ADD,  3, 2, 1, 0);
        add_instr(SUB,  4, 3, 2, 0);
        add_instr(AND,  5, 4, 3, 0);
        add_instr(OR,   6, 5, 2, 0);
        add_instr(XOR,  0, 6, 3, 0);
        add_instr(ST,   0, 7, 0, 'h0010);
        add_instr(HALT, 0, 0, 0, 0);

        begin_test(1, "load_use", 16'h3d3d, 16'h0020, 16'h3d3d);
        data_tab[1][2] = 16'h3c3c;
        add_instr(XOR,  7, 7, 7, 0);
        add_instr(ADDI, 2, 7, 0, 'h0101);
        add_instr(LD,   1, 7, 0, 'h0002);
        add_instr(ADD,  0, 1, 2, 0);          // uses the loaded word at once
        add_instr(ST,   0, 7, 0, 'h0020);
        add_instr(HALT, 0, 0, 0, 0);

        begin_test(2, "store_load", 16'hbeef, 16'h0035, 16'hbeef);
        add_instr(XOR,  7, 7, 7, 0);
        add_instr(ADDI, 1, 7, 0, 'hbeef);
        add_instr(ADDI, 2, 7, 0, 'h0030);
        add_instr(ST,   0, 2, 1, 'h0005);
        add_instr(LD,   0, 2, 0, 'h0005);
        add_instr(HALT, 0, 0, 0, 0);

        begin_test(3, "branch_flush", 16'h0042, 16'h0050, 16'h0042);
        add_instr(XOR,  7, 7, 7, 0);
        add_instr(ADDI, 1, 7, 0, 'h0003);
        add_instr(BEQZ, 0, 1, 0, 11);         // not taken
        add_instr(ADDI, 0, 7, 0, 'h0040);
        add_instr(BEQZ, 0, 7, 0, 7);          // taken
        add_instr(ADDI, 0, 0, 0, 'h0100);
        add_instr(ADDI, 0, 0, 0, 'h0200);
        add_instr(JMP,  0, 0, 0, 9);
        add_instr(ADDI, 0, 0, 0, 'h0400);
        add_instr(ADDI, 0, 0, 0, 'h0002);
        add_instr(ST,   0, 7, 0, 'h0050);
        add_instr(HALT, 0, 0, 0, 0);

        begin_test(4, "count_loop", 16'h0033, 16'h0060, 16'h0033);
        add_instr(XOR,  7, 7, 7, 0);
        add_instr(ADDI, 1, 7, 0, 'h0003);     // three passes
        add_instr(XOR,  0, 0, 0, 0);
        add_instr(ADDI, 0, 0, 0, 'h0011);
        add_instr(ADDI, 1, 1, 0, 'hffff);
        add_instr(BEQZ, 0, 1, 0, 7);
        add_instr(JMP,  0, 0, 0, 3);
        add_instr(ST,   0, 7, 0, 'h0060);
        add_instr(HALT, 0, 0, 0, 0);
    endtask

    // instruction memory with one response pulse per request
    always @(posedge clk) begin
        if (!arst_n) begin
            for (int a = 0; a < MEM_WORDS; a++) begin
                imem[a] <= halt_fill(a);
            end
            for (int n = 0; n < PROG_WORDS; n++) begin
                imem[n] <= prog_tab[cur_test][n];
            end
            req_data_valid <= 1'b0;
            ireq_wait      <= pick_ack_delay();   // delay of the next request
        end else if (req_data_valid) begin
            req_data_valid <= 1'b0;
        end else if (req_valid) begin
            if (ireq_wait == 1) begin
                req_data       <= imem[req_addr[7:0]];
                req_data_valid <= 1'b1;
                ireq_wait      <= pick_ack_delay();
            end else begin
                ireq_wait <= ireq_wait - 1;
            end
        end
    end

    // data memory whose ack pulse ends the held request
    always @(posedge clk) begin
        if (!arst_n) begin
            for (int a = 0; a < MEM_WORDS; a++) begin
                dmem[a] <= data_fill(a);
            end
            for (int n = 0; n < INIT_WORDS; n++) begin
                dmem[n] <= data_tab[cur_test][n];
            end
            mem_ack   <= 1'b0;
            dreq_wait <= pick_ack_delay();
        end else if (mem_ack) begin
            mem_ack <= 1'b0;
        end else if (mem_req) begin
            if (dreq_wait == 1) begin
                mem_rdata <= dmem[mem_addr[7:0]];
                if (mem_we) begin
                    dmem[mem_addr[7:0]] <= mem_wdata;
                end
                mem_ack   <= 1'b1;
                dreq_wait <= pick_ack_delay();
            end else begin
                dreq_wait <= dreq_wait - 1;
            end
        end
    end

    task automatic restart_core();
        @(posedge clk);
        rst_req <= 1'b1;
        @(posedge clk);
        rst_req <= 1'b0;
        wait (arst_n == 1'b0);
        wait (arst_n == 1'b1);
    endtask

    task automatic check_after_reset();
        @(posedge clk);   // first edge out of reset issues the fetch
        @(negedge clk);
        check_value("o_mem_req", RW'(mem_req), '0);
        check_value("o_halted", RW'(halted), '0);
        check_value("o_dbg_pc", dbg_pc, '0);
        check_value("o_req_valid", RW'(req_valid), RW'(1'b1));
    endtask

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("timeout: a program did not halt within %0d cycles", LIMIT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int t;
        int errors_before;

        void'($urandom(SEED));
        build_table();
        wait (arst_n == 1'b1);
        for (int run = 0; run < RUNS; run++) begin
            t = run % N_TESTS;
            errors_before = errors;
            cur_test = t;
            fixed_delay = (run >= N_TESTS);
            restart_core();
            check_after_reset();
            while (halted !== 1'b1) @(negedge clk);
            check_value("o_dbg_r0", dbg_r0, exp_r0[t]);
            check_value($sformatf("dmem[%h]", exp_addr[t]), dmem[exp_addr[t][7:0]],
                        exp_word[t]);
            if (errors == errors_before) begin
                passed++;
            end else begin
                failed++;
            end
            $display("run %0d %s, %s acks, r0=%h: %s", run, test_name[t],
                     fixed_delay ? "1-cycle" : "random", dbg_r0,
                     (errors == errors_before) ? "ok" : "failed");
        end
        $display("runs %0d, passed %0d, failed %0d, mismatches %0d",
                 RUNS, passed, failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== core.f ====
logic/core_pkg.sv
logic/fetch.sv
logic/decode.sv
logic/execute.sv
logic/memwb.sv
logic/core.sv
tests/tb_clkgen.sv
tests/core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing -j 0
TOP       := core_tb
FILELIST  := core.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := >>> PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
